// ==== sources.f ====
+incdir+include
logic/sv32_pkg.sv
logic/mem_pkg.sv
logic/dtlb.sv
logic/ptw.sv
logic/mmu_ctrl.sv
logic/mmu_top.sv
dv/page_mem.sv
dv/mmu_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the data MMU testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f sources.f --top-module mmu_tb -o mmu_sim

./obj_dir/mmu_sim | tee sim.log

if grep -qx "Verification passed" sim.log; then
    echo "Simulation result: PASS"
else
    echo "Simulation result: FAIL"
    exit 1
fi

// ==== dv/mmu_tb.sv ====
`timescale 1ns/1ps
`include "mmu_macros.svh"

module mmu_tb import sv32_pkg::*, mem_pkg::*; ();

    localparam int N_DIRECTED      = 21;
    localparam int N_RANDOM        = 40;
    localparam int N_REQ           = N_DIRECTED + N_RANDOM;
    localparam int WATCHDOG_CYCLES = N_REQ * 40 + 10;

    // Walk expectation per request
    localparam int WALK_ANY = 0;
    localparam int WALK_NO  = 1;
    localparam int WALK_YES = 2;

    localparam logic [21:0] ROOT_PPN = 22'h000001;
    localparam logic [21:0] L0_PPN   = 22'h000002;

    // PTE flag bytes in D A G U X W R V order
    localparam logic [7:0] F_PTR = 8'h01;
    localparam logic [7:0] F_RW  = 8'hC7;
    localparam logic [7:0] F_RO  = 8'hC3;
    localparam logic [7:0] F_XO  = 8'hC9;
    localparam logic [7:0] F_WO  = 8'hC5;
    localparam logic [7:0] F_NOA = 8'h87;

    logic              clk;
    logic              rst_n;
    logic [`PPN_W-1:0] satp_ppn;
    logic              req_valid;
    logic              req_ready;
    xlat_req_s         req;
    logic              rsp_valid;
    logic              rsp_ready;
    xlat_rsp_s         rsp;
    logic              mem_req_valid;
    logic              mem_req_ready;
    mem_req_s          mem_req;
    logic              mem_rsp_valid;
    mem_rsp_s          mem_rsp;

    // Expected responses in request order
    xlat_rsp_s exp_rsp [$];
    int        exp_walk [$];
    string     exp_name [$];
    xlat_rsp_s exp_cur = '0;
    int        exp_walk_cur = WALK_ANY;
    string     exp_name_cur = "none";

    int     n_acc;
    int     rsp_idx;
    int     mem_cnt;
    int     val_errs = 0;
    int     proto_errs = 0;
    integer seed = 32'h0232e5e2;
    integer ready_seed = 32'h0232e5e2;

    mmu_top dut0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .satp_ppn      (satp_ppn),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .req           (req),
        .rsp_valid     (rsp_valid),
        .rsp_ready     (rsp_ready),
        .rsp           (rsp),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_req       (mem_req),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp       (mem_rsp)
    );

    page_mem u_mem (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (mem_req_valid),
        .req_ready (mem_req_ready),
        .req       (mem_req),
        .rsp_valid (mem_rsp_valid),
        .rsp       (mem_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] pte_word(logic [21:0] ppn, logic [7:0] flags);
        return {ppn, 2'b00, flags};
    endfunction

    // Word at table base times 4096 plus index times 4
    function automatic logic [31:0] table_word(logic [21:0] ppn, logic [9:0] idx);
        logic [`PA_W-1:0] addr;
        addr = {ppn, idx, 2'b00};
        return u_mem.mem[addr[13:2]];
    endfunction

    task automatic put_pte(input logic [21:0] ppn, input logic [9:0] idx,
                           input logic [31:0] word);
        logic [`PA_W-1:0] addr;
        addr = {ppn, idx, 2'b00};
        u_mem.mem[addr[13:2]] = word;
    endtask

    task automatic build_tables();
        // Root table
        put_pte(ROOT_PPN, 10'h001, pte_word(L0_PPN, F_PTR));
        put_pte(ROOT_PPN, 10'h002, pte_word({12'h0A5, 10'h000}, F_RW));
        put_pte(ROOT_PPN, 10'h003, pte_word({12'h0B7, 10'h005}, F_RW));
        put_pte(ROOT_PPN, 10'h004, pte_word(22'h01234, 8'h00));
        put_pte(ROOT_PPN, 10'h005, pte_word(22'h00333, F_WO));
        put_pte(ROOT_PPN, 10'h011, pte_word({12'h03C, 10'h000}, F_RO));
        // Level 0 table behind vpn_1 of 1
        put_pte(L0_PPN, 10'h000, pte_word(22'h12345, F_RW));
        put_pte(L0_PPN, 10'h001, pte_word(22'h0ABCD, F_RO));
        put_pte(L0_PPN, 10'h002, pte_word(22'h00777, F_XO));
        put_pte(L0_PPN, 10'h003, pte_word(22'h2468A, F_NOA));
        put_pte(L0_PPN, 10'h004, pte_word(22'h13579, F_WO));
        put_pte(L0_PPN, 10'h005, pte_word(22'h00003, F_PTR));
        put_pte(L0_PPN, 10'h006, pte_word(22'h3FFFF, 8'h00));
    endtask

    // Sv32 walk over the model memory with all-zero faulting answers
    function automatic xlat_rsp_s expected_rsp(logic [19:0] vpn, access_e acc);
        xlat_rsp_s o;
        sv32_pte_s pte;
        logic      big;
        logic      bad;
        o = '0;
        if (acc != ACC_FLUSH) begin
            pte = sv32_pte_s'(table_word(satp_ppn, vpn[19:10]));
            big = pte.r || pte.x;
            bad = !pte.v || (pte.w && !pte.r);
            if (!bad && !big) begin
                pte = sv32_pte_s'(table_word({pte.ppn1, pte.ppn0}, vpn[9:0]));
                bad = !pte.v || (pte.w && !pte.r) || !(pte.r || pte.x);
            end
            bad = bad || !pte.a || (big && pte.ppn0 != 10'h000);
            bad = bad || (acc == ACC_LOAD && !pte.r) || (acc == ACC_STORE && !pte.w);
            if (!bad) begin
                o.page_4M = big;
                o.ppn     = big ? {pte.ppn1, vpn[9:0]} : {pte.ppn1, pte.ppn0};
            end
            o.fault = bad;
        end
        return o;
    endfunction

    // Called on a falling edge and returns once the request is taken
    task automatic send_req(input logic [19:0] vpn, input access_e acc,
                            input int walk, input string name);
        exp_rsp.push_back(expected_rsp(vpn, acc));
        exp_walk.push_back(walk);
        exp_name.push_back(name);
        req       = '{vpn: vpn, access: acc};
        req_valid = 1'b1;
        while (!req_ready) @(negedge clk);
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    function automatic logic [19:0] pool_vpn(int k);
        case (k)
            0:       return {10'h001, 10'h000};
            1:       return {10'h001, 10'h001};
            2:       return {10'h001, 10'h002};
            3:       return {10'h001, 10'h003};
            4:       return {10'h001, 10'h004};
            5:       return {10'h001, 10'h005};
            6:       return {10'h001, 10'h006};
            7:       return {10'h002, 10'h123};
            8:       return {10'h002, 10'h3FF};
            9:       return {10'h003, 10'h000};
            10:      return {10'h004, 10'h000};
            11:      return {10'h005, 10'h000};
            12:      return {10'h011, 10'h010};
            default: return {10'h012, 10'h007};
        endcase
    endfunction

    task automatic random_reqs();
        int      k;
        int      r;
        access_e acc;
        for (int n = 0; n < N_RANDOM; n++) begin
            k = $unsigned($random(seed)) % 14;
            r = $unsigned($random(seed)) % 8;
            // One in eight is a flush
            if (r == 0) begin
                acc = ACC_FLUSH;
            end else if (r < 5) begin
                acc = ACC_LOAD;
            end else begin
                acc = ACC_STORE;
            end
            send_req(pool_vpn(k), acc, WALK_ANY, "random");
        end
    endtask

    // Random back-pressure on the response
    initial begin
        rsp_ready = 1'b0;
        forever begin
            @(negedge clk);
            rsp_ready = ($random(ready_seed) & 3) != 0;
        end
    end

    // Head of the expected queue settles before each rising edge
    always @(negedge clk) begin
        if (rsp_idx < exp_rsp.size()) begin
            exp_cur      <= exp_rsp[rsp_idx];
            exp_walk_cur <= exp_walk[rsp_idx];
            exp_name_cur <= exp_name[rsp_idx];
        end
    end

    // Memory reads seen since the last accepted request
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            n_acc   <= 0;
            rsp_idx <= 0;
            mem_cnt <= 0;
        end else begin
            if (req_valid && req_ready) begin
                n_acc   <= n_acc + 1;
                mem_cnt <= 0;
            end else if (mem_req_valid && mem_req_ready) begin
                mem_cnt <= mem_cnt + 1;
            end
            if (rsp_valid && rsp_ready) begin
                rsp_idx <= rsp_idx + 1;
            end
        end
    end

    a_rsp_value: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid && rsp_ready |-> rsp == exp_cur)
        else begin
            val_errs++;
            $display("** Error: %s expected ppn=%h 4M=%b fault=%b, actual ppn=%h 4M=%b fault=%b",
                     exp_name_cur, exp_cur.ppn, exp_cur.page_4M, exp_cur.fault,
                     rsp.ppn, rsp.page_4M, rsp.fault);
        end

    a_hit_no_walk: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid && rsp_ready && exp_walk_cur == WALK_NO |-> mem_cnt == 0)
        else begin
            val_errs++;
            $display("** Error: %s expected 0 table reads, actual %0d", exp_name_cur, mem_cnt);
        end

    a_miss_walks: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid && rsp_ready && exp_walk_cur == WALK_YES |-> mem_cnt != 0)
        else begin
            val_errs++;
            $display("** Error: %s expected a table walk, actual 0 table reads", exp_name_cur);
        end

    a_one_rsp: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid && rsp_ready |-> rsp_idx < n_acc)
        else begin
            proto_errs++;
            $display("A response came back with no request outstanding");
        end

    a_rsp_stable: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
        else begin
            proto_errs++;
            $display("A stalled response changed or dropped before it was taken");
        end

    a_reset_idle: assert property (@(posedge clk)
        $rose(rst_n) |-> req_ready && !rsp_valid && !mem_req_valid)
        else begin
            proto_errs++;
            $display("The DUT was not idle when reset was released");
        end

    a_mem_range: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req_valid |-> mem_req.addr[`PA_W-1:14] == '0)
        else begin
            proto_errs++;
            $display("A table read pointed outside the modelled page tables");
        end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired: %0d of %0d responses, %0d value errors, %0d protocol errors",
                 rsp_idx, exp_rsp.size(), val_errs, proto_errs);
        $display("Verification failed");
        $finish;
    end

    initial begin
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        satp_ppn  = ROOT_PPN;
        @(negedge clk);
        build_tables();
        repeat (9) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // Fill, hits and superpage region
        send_req({10'h001, 10'h000}, ACC_LOAD,  WALK_YES, "load_4k");
        send_req({10'h001, 10'h000}, ACC_LOAD,  WALK_NO,  "load_4k_hit");
        send_req({10'h001, 10'h000}, ACC_STORE, WALK_NO,  "store_4k_hit");
        send_req({10'h002, 10'h123}, ACC_LOAD,  WALK_YES, "load_super");
        send_req({10'h002, 10'h3FF}, ACC_STORE, WALK_NO,  "store_super_hit");
        // Same slot with another vpn_1
        send_req({10'h011, 10'h010}, ACC_LOAD,  WALK_YES, "index_alias_walk");
        send_req({10'h011, 10'h020}, ACC_STORE, WALK_NO,  "store_no_w_super");
        send_req({10'h001, 10'h000}, ACC_LOAD,  WALK_YES, "evicted_rewalk");
        // Flush then walk again
        send_req({10'h001, 10'h000}, ACC_FLUSH, WALK_NO,  "flush");
        send_req({10'h001, 10'h000}, ACC_LOAD,  WALK_YES, "after_flush_walk");
        send_req({10'h002, 10'h005}, ACC_LOAD,  WALK_YES, "super_after_flush");
        // Walk faults
        send_req({10'h004, 10'h000}, ACC_LOAD,  WALK_YES, "invalid_l1");
        send_req({10'h005, 10'h000}, ACC_LOAD,  WALK_YES, "w_no_r_l1");
        send_req({10'h003, 10'h000}, ACC_LOAD,  WALK_YES, "misaligned_super");
        send_req({10'h001, 10'h003}, ACC_LOAD,  WALK_YES, "a_clear");
        // Permission faults still refill
        send_req({10'h001, 10'h001}, ACC_STORE, WALK_YES, "store_no_w");
        send_req({10'h001, 10'h001}, ACC_STORE, WALK_NO,  "store_no_w_hit");
        send_req({10'h001, 10'h002}, ACC_LOAD,  WALK_YES, "load_no_r");
        send_req({10'h001, 10'h004}, ACC_LOAD,  WALK_YES, "w_no_r_l0");
        send_req({10'h001, 10'h005}, ACC_LOAD,  WALK_YES, "leaf_missing");
        send_req({10'h001, 10'h006}, ACC_LOAD,  WALK_YES, "invalid_l0");

        random_reqs();

        while (rsp_idx != exp_rsp.size()) @(negedge clk);
        repeat (4) @(negedge clk);
        $display("Summary: %0d requests, %0d responses, %0d value errors, %0d protocol errors",
                 exp_rsp.size(), rsp_idx, val_errs, proto_errs);
        if (val_errs == 0 && proto_errs == 0 && n_acc == exp_rsp.size()) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== dv/page_mem.sv ====
`timescale 1ns/1ps
`include "mmu_macros.svh"

module page_mem import mem_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     req_valid,
    output logic     req_ready,
    input  mem_req_s req,
    output logic     rsp_valid,
    output mem_rsp_s rsp
);

    // Four 4 KiB pages with the page tables in pages 1 and 2
    localparam int WORDS = 4096;

    logic [`PTE_W-1:0] mem [0:WORDS-1];
    logic [11:0]       word_q;
    logic [1:0]        wait_q;
    integer            seed = 32'h0232e5e2;

    // Background words all have V clear
    initial begin
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = {i[30:0], 1'b0};
        end
    end

    // A read accepted at a rising edge returns data two edges later
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wait_q <= 2'd0;
            word_q <= '0;
        end else if (req_valid && req_ready) begin
            wait_q <= 2'd2;
            word_q <= req.addr[13:2];
        end else if (wait_q != 2'd0) begin
            wait_q <= wait_q - 2'd1;
        end
    end

    // Outputs change on the falling edge
    always @(negedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_ready <= 1'b0;
            rsp_valid <= 1'b0;
            rsp       <= '0;
        end else begin
            // Ready about three cycles in four
            req_ready <= ($random(seed) & 3) != 0;
            rsp_valid <= (wait_q == 2'd1);
            rsp.data  <= mem[word_q];
        end
    end

endmodule

// ==== logic/mmu_top.sv ====
`timescale 1ns/1ps
`include "mmu_macros.svh"

module mmu_top import sv32_pkg::*, mem_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [`PPN_W-1:0] satp_ppn,
    // Translation request and response
    input  logic              req_valid,
    output logic              req_ready,
    input  xlat_req_s         req,
    output logic              rsp_valid,
    input  logic              rsp_ready,
    output xlat_rsp_s         rsp,
    // Page table memory
    output logic              mem_req_valid,
    input  logic              mem_req_ready,
    output mem_req_s          mem_req,
    input  logic              mem_rsp_valid,
    input  mem_rsp_s          mem_rsp
);

    logic [`VPN_W-1:0] lookup_vpn;
    tlb_lookup_s       lookup;
    logic              tlb_flush;
    logic              tlb_update;
    walk_result_s      tlb_fill;
    logic              walk_valid;
    logic              walk_ready;
    logic [`VPN_W-1:0] walk_vpn;
    logic              walk_done;
    walk_result_s      walk_result;

    mmu_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .req         (req),
        .rsp_valid   (rsp_valid),
        .rsp_ready   (rsp_ready),
        .rsp         (rsp),
        .lookup_vpn  (lookup_vpn),
        .lookup      (lookup),
        .tlb_flush   (tlb_flush),
        .tlb_update  (tlb_update),
        .tlb_fill    (tlb_fill),
        .walk_valid  (walk_valid),
        .walk_ready  (walk_ready),
        .walk_vpn    (walk_vpn),
        .walk_done   (walk_done),
        .walk_result (walk_result)
    );

    dtlb u_tlb (
        .clk        (clk),
        .rst_n      (rst_n),
        .lookup_vpn (lookup_vpn),
        .lookup     (lookup),
        .flush      (tlb_flush),
        .update     (tlb_update),
        .fill       (tlb_fill)
    );

    // Walker alone owns the memory port
    ptw u_ptw (
        .clk           (clk),
        .rst_n         (rst_n),
        .satp_ppn      (satp_ppn),
        .start_valid   (walk_valid),
        .start_ready   (walk_ready),
        .start_vpn     (walk_vpn),
        .done          (walk_done),
        .result        (walk_result),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_req       (mem_req),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp       (mem_rsp)
    );

endmodule

// ==== logic/mmu_ctrl.sv ====
`timescale 1ns/1ps
`include "mmu_macros.svh"

module mmu_ctrl import sv32_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    // Load/store unit side
    input  logic              req_valid,
    output logic              req_ready,
    input  xlat_req_s         req,
    output logic              rsp_valid,
    input  logic              rsp_ready,
    output xlat_rsp_s         rsp,
    // TLB
    output logic [`VPN_W-1:0] lookup_vpn,
    input  tlb_lookup_s       lookup,
    output logic              tlb_flush,
    output logic              tlb_update,
    output walk_result_s      tlb_fill,
    // Walker
    output logic              walk_valid,
    input  logic              walk_ready,
    output logic [`VPN_W-1:0] walk_vpn,
    input  logic              walk_done,
    input  walk_result_s      walk_result
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_WALK,
        S_WAIT,
        S_RESP
    } state_e;

    state_e    state_q;
    state_e    state_d;
    xlat_req_s req_q;
    xlat_rsp_s rsp_q;
    xlat_rsp_s rsp_d;
    logic      rsp_load;
    logic      is_flush;

    // Join the physical page and apply R/W permission
    function automatic xlat_rsp_s make_rsp(sv32_pte_s pte, logic page_4M,
                                           logic walk_fault, xlat_req_s r);
        xlat_rsp_s o;
        logic      perm_fault;
        perm_fault = (r.access == ACC_LOAD && !pte.r) || (r.access == ACC_STORE && !pte.w);
        o.fault    = walk_fault || perm_fault;
        o.page_4M  = page_4M && !o.fault;
        // Superpage takes ppn0 from the virtual side
        o.ppn      = page_4M ? {pte.ppn1, r.vpn[9:0]} : {pte.ppn1, pte.ppn0};
        if (o.fault) begin
            o.ppn = '0;
        end
        return o;
    endfunction

    assign is_flush   = (req_q.access == ACC_FLUSH);
    assign lookup_vpn = req_q.vpn;
    assign walk_vpn   = req_q.vpn;

    assign req_ready  = (state_q == S_IDLE);
    assign rsp_valid  = (state_q == S_RESP);
    assign rsp        = rsp_q;
    assign walk_valid = (state_q == S_WALK);

    // Flush lands at the edge that raises rsp_valid
    assign tlb_flush  = (state_q == S_LOOKUP) && is_flush;
    // Refill even on a permission fault
    assign tlb_update = (state_q == S_WAIT) && walk_done && !walk_result.fault;
    assign tlb_fill   = walk_result;

    always_comb begin
        state_d  = state_q;
        rsp_d    = '0;
        rsp_load = 1'b0;
        case (state_q)
            S_IDLE: begin
                if (req_valid) begin
                    state_d = S_LOOKUP;
                end
            end
            S_LOOKUP: begin
                // Flush answers with an all-zero response
                if (is_flush) begin
                    rsp_load = 1'b1;
                    state_d  = S_RESP;
                end else if (lookup.hit) begin
                    rsp_d    = make_rsp(lookup.pte, lookup.page_4M, 1'b0, req_q);
                    rsp_load = 1'b1;
                    state_d  = S_RESP;
                end else begin
                    state_d = S_WALK;
                end
            end
            S_WALK: begin
                if (walk_ready) begin
                    state_d = S_WAIT;
                end
            end
            S_WAIT: begin
                if (walk_done) begin
                    rsp_d    = make_rsp(walk_result.pte, walk_result.page_4M,
                                        walk_result.fault, req_q);
                    rsp_load = 1'b1;
                    state_d  = S_RESP;
                end
            end
            default: begin
                // Hold until taken
                if (rsp_ready) begin
                    state_d = S_IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            req_q <= req;
        end
        if (rsp_load) begin
            rsp_q <= rsp_d;
        end
    end

    a_rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp));

    // Walker completes only a walk this block started
    a_done_expected: assert property (@(posedge clk) disable iff (!rst_n)
        walk_done |-> state_q == S_WAIT);

endmodule

// ==== logic/ptw.sv ====
`timescale 1ns/1ps
`include "mmu_macros.svh"

module ptw import sv32_pkg::*, mem_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [`PPN_W-1:0] satp_ppn,
    // Walk start from the controller
    input  logic              start_valid,
    output logic              start_ready,
    input  logic [`VPN_W-1:0] start_vpn,
    // One-cycle completion
    output logic              done,
    output walk_result_s      result,
    // Memory read port
    output logic              mem_req_valid,
    input  logic              mem_req_ready,
    output mem_req_s          mem_req,
    input  logic              mem_rsp_valid,
    input  mem_rsp_s          mem_rsp
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_REQ1,
        S_WAIT1,
        S_REQ0,
        S_WAIT0,
        S_DONE
    } state_e;

    state_e            state_q;
    state_e            state_d;

    // Walk payload
    sv32_vpn_s         vpn_q;
    logic [`PPN_W-1:0] base_q;
    walk_result_s      result_q;

    sv32_pte_s         rsp_pte;
    logic              rsp_take;
    logic              rsp_leaf;
    logic              misaligned;
    logic              rsp_fault;
    logic              descend;

    assign rsp_pte  = sv32_pte_s'(mem_rsp.data);
    assign rsp_take = mem_rsp_valid && (state_q == S_WAIT1 || state_q == S_WAIT0);
    assign rsp_leaf = pte_is_leaf(rsp_pte);

    // 4 MiB leaf needs ppn0 of zero
    assign misaligned = (state_q == S_WAIT1) && rsp_leaf && (rsp_pte.ppn0 != '0);

    // Invalid, reserved W without R, A clear, misaligned, or no leaf at level 0
    assign rsp_fault = !rsp_pte.v
                    || (rsp_pte.w && !rsp_pte.r)
                    || (rsp_leaf && !rsp_pte.a)
                    || misaligned
                    || (!rsp_leaf && state_q == S_WAIT0);

    // Valid pointer at level 1
    assign descend = rsp_take && (state_q == S_WAIT1) && !rsp_fault && !rsp_leaf;

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (start_valid) begin
                    state_d = S_REQ1;
                end
            end
            S_REQ1: begin
                if (mem_req_ready) begin
                    state_d = S_WAIT1;
                end
            end
            S_WAIT1: begin
                if (descend) begin
                    state_d = S_REQ0;
                end else if (rsp_take) begin
                    state_d = S_DONE;
                end
            end
            S_REQ0: begin
                if (mem_req_ready) begin
                    state_d = S_WAIT0;
                end
            end
            S_WAIT0: begin
                if (rsp_take) begin
                    state_d = S_DONE;
                end
            end
            default: begin
                state_d = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        // Root table comes from satp
        if (start_valid && start_ready) begin
            vpn_q  <= sv32_vpn_s'(start_vpn);
            base_q <= satp_ppn;
        end
        if (descend) begin
            base_q <= {rsp_pte.ppn1, rsp_pte.ppn0};
        end
        // Level 0 reply overwrites a level 1 pointer
        if (rsp_take) begin
            result_q <= '{
                vpn:     vpn_q,
                pte:     rsp_pte,
                page_4M: (state_q == S_WAIT1) && rsp_leaf,
                fault:   rsp_fault
            };
        end
    end

    assign start_ready   = (state_q == S_IDLE);
    assign done          = (state_q == S_DONE);
    assign result        = result_q;
    assign mem_req_valid = (state_q == S_REQ1) || (state_q == S_REQ0);

    // Table base times 4096 plus index times 4
    assign mem_req.addr = {base_q, (state_q == S_REQ0) ? vpn_q.vpn_0 : vpn_q.vpn_1, 2'b00};

    a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req));

    // Memory only answers an accepted read
    a_no_stray_rsp: assert property (@(posedge clk) disable iff (!rst_n)
        mem_rsp_valid |-> (state_q == S_WAIT1 || state_q == S_WAIT0));

endmodule

// ==== logic/dtlb.sv ====
`timescale 1ns/1ps
`include "mmu_macros.svh"

module dtlb import sv32_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    // Combinational lookup
    input  logic [`VPN_W-1:0] lookup_vpn,
    output tlb_lookup_s       lookup,
    // Maintenance from the controller
    input  logic              flush,
    input  logic              update,
    input  walk_result_s      fill
);

    tlb_entry_s             entry_q [`DTLB_ENTRIES];

    logic [`DTLB_WIDTH-1:0] rd_idx;
    logic [`DTLB_WIDTH-1:0] wr_idx;
    sv32_vpn_s              rd_vpn;
    tlb_entry_s             rd_entry;

    // Index from low vpn_1 bits so a superpage owns exactly one slot
    assign rd_idx   = lookup_vpn[`DTLB_WIDTH+9:10];
    assign wr_idx   = fill.vpn[`DTLB_WIDTH+9:10];
    assign rd_vpn   = sv32_vpn_s'(lookup_vpn);
    assign rd_entry = entry_q[rd_idx];

    always_comb begin
        lookup = '0;
        // Tag compare on vpn_1 first
        if (rd_entry.valid && (rd_entry.vpn_1 == rd_vpn.vpn_1)) begin
            // Superpage matches any vpn_0
            if (rd_entry.page_4M || (rd_entry.vpn_0 == rd_vpn.vpn_0)) begin
                lookup.hit     = 1'b1;
                lookup.page_4M = rd_entry.page_4M;
                lookup.pte     = rd_entry.pte;
            end
        end
    end

    // Flush wins over update and clears only the valid bits
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `DTLB_ENTRIES; i++) begin
                entry_q[i] <= '0;
            end
        end else if (flush) begin
            for (int i = 0; i < `DTLB_ENTRIES; i++) begin
                entry_q[i].valid <= 1'b0;
            end
        end else if (update) begin
            entry_q[wr_idx] <= '{
                valid:   1'b1,
                vpn_1:   fill.vpn[`VPN_W-1:10],
                vpn_0:   fill.vpn[9:0],
                page_4M: fill.page_4M,
                pte:     fill.pte
            };
        end
    end

    // Controller never flushes and refills together
    a_flush_update_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(flush && update));

    // Walker faults never reach the array
    a_fill_clean: assert property (@(posedge clk) disable iff (!rst_n)
        update |-> !fill.fault);

endmodule

// ==== logic/mem_pkg.sv ====
`include "mmu_macros.svh"

package mem_pkg;

    // Read of one PTE word by byte address
    typedef struct packed {
        logic [`PA_W-1:0] addr;
    } mem_req_s;

    // Read data for the single outstanding request
    typedef struct packed {
        logic [`PTE_W-1:0] data;
    } mem_rsp_s;

endpackage

// ==== logic/sv32_pkg.sv ====
`include "mmu_macros.svh"

package sv32_pkg;

    // Virtual page number split into its two table indices
    typedef struct packed {
        logic [9:0] vpn_1;
        logic [9:0] vpn_0;
    } sv32_vpn_s;

    // Page table entry with V in bit 0
    typedef struct packed {
        logic [11:0] ppn1;
        logic [9:0]  ppn0;
        logic [1:0]  rsw;
        logic        d;
        logic        a;
        logic        g;
        logic        u;
        logic        x;
        logic        w;
        logic        r;
        logic        v;
    } sv32_pte_s;

    // One TLB slot
    typedef struct packed {
        logic       valid;
        logic [9:0] vpn_1;
        logic [9:0] vpn_0;
        logic       page_4M;
        sv32_pte_s  pte;
    } tlb_entry_s;

    // Request kind from the load/store unit
    typedef enum logic [1:0] {
        ACC_LOAD  = 2'd0,
        ACC_STORE = 2'd1,
        ACC_FLUSH = 2'd2
    } access_e;

    typedef struct packed {
        logic [`VPN_W-1:0] vpn;
        access_e           access;
    } xlat_req_s;

    // Faulting responses carry zero ppn and page_4M
    typedef struct packed {
        logic [`PPN_W-1:0] ppn;
        logic              page_4M;
        logic              fault;
    } xlat_rsp_s;

    typedef struct packed {
        logic      hit;
        logic      page_4M;
        sv32_pte_s pte;
    } tlb_lookup_s;

    // Outcome of one table walk and the TLB fill payload
    typedef struct packed {
        logic [`VPN_W-1:0] vpn;
        sv32_pte_s         pte;
        logic              page_4M;
        logic              fault;
    } walk_result_s;

    // Leaf when any of R or X is set
    function automatic logic pte_is_leaf(sv32_pte_s pte);
        return pte.r || pte.x;
    endfunction

endpackage

// ==== include/mmu_macros.svh ====
`ifndef MMU_MACROS_SVH
`define MMU_MACROS_SVH

// Number of TLB entries as a power of two up to 1024
`define DTLB_ENTRIES 16

// Index bits taken from the low end of vpn_1
`define DTLB_WIDTH ($clog2(`DTLB_ENTRIES))

// Sv32 page number widths
`define VPN_W 20
`define PPN_W 22

// Physical byte address and PTE word width
`define PA_W  34
`define PTE_W 32

`endif
